//--- hw/exu_pkg.sv
// Execute stage definitions

package exu_pkg;

  localparam int XLEN = 64;

  // queue entries and the upstream credits after reset
  localparam int EXU_QDEPTH     = 4;
  localparam int EXU_WB_CREDITS = 2;
  localparam int EXU_DIV_CYCLES = 64;

  typedef logic [XLEN-1:0]                        xlen_t;
  typedef logic [$clog2(EXU_QDEPTH)-1:0]          qptr_t;
  typedef logic [$clog2(EXU_QDEPTH+1)-1:0]        qcnt_t;
  typedef logic [$clog2(EXU_WB_CREDITS+1)-1:0]    wb_cnt_t;
  typedef logic [$clog2(EXU_DIV_CYCLES)-1:0]      div_cnt_t;
  typedef logic [5:0]                             shamt_t;

  typedef enum logic [4:0] {
    alu_add      = 5'b00000,
    alu_sll      = 5'b00001,
    alu_slt      = 5'b00010,
    alu_copy_imm = 5'b00011,
    alu_xor      = 5'b00100,
    alu_srl      = 5'b00101,
    alu_or       = 5'b00110,
    alu_and      = 5'b00111,
    alu_sub      = 5'b01000,
    alu_sltu     = 5'b01010,
    alu_sra      = 5'b01101,
    alu_remu     = 5'b11001,
    alu_divu     = 5'b11010,
    alu_div      = 5'b11011,
    alu_mul      = 5'b11100,
    alu_rem      = 5'b11101,
    alu_ebreak   = 5'b11110,
    alu_illegal  = 5'b11111
  } alu_op_e;

  typedef enum logic {asrc_rs1 = 1'b0, asrc_pc = 1'b1} asrc_e;

  typedef enum logic [1:0] {
    bsrc_rs2  = 2'b00,
    bsrc_imm  = 2'b01,
    bsrc_four = 2'b10
  } bsrc_e;

  typedef enum logic [2:0] {
    br_none = 3'b000,
    br_jal  = 3'b001,
    br_jalr = 3'b010,
    br_beq  = 3'b100,
    br_bne  = 3'b101,
    br_blt  = 3'b110,
    br_bge  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    mem_lb  = 3'b000,
    mem_lbu = 3'b001,
    mem_lh  = 3'b010,
    mem_lhu = 3'b011,
    mem_lw  = 3'b100,
    mem_lwu = 3'b101,
    mem_ld  = 3'b110
  } memop_e;

  typedef enum logic [1:0] {
    st_ok      = 2'b00,
    st_ebreak  = 2'b01,
    st_illegal = 2'b10
  } status_e;

  typedef struct packed {
    alu_op_e alu_op;
    asrc_e   asrc;
    bsrc_e   bsrc;
    logic    word_cut;
    branch_e branch;
    memop_e  memop;
    logic    mem_to_reg;
    xlen_t   rs1;
    xlen_t   rs2;
    xlen_t   imm;
    xlen_t   pc;
    // load data, already read by the memory stage
    xlen_t   rdata;
  } exu_op_t;

  typedef struct packed {
    xlen_t   wb_data;
    xlen_t   alu_result;
    xlen_t   next_pc;
    status_e status;
  } exu_res_t;

endpackage

//--- hw/exu_issue_fifo.sv
// Operation issue queue

`timescale 1ns/1ps

module exu_issue_fifo (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_push,
  input  exu_pkg::exu_op_t i_push_op,
  input  logic             i_pop,
  output logic             o_head_valid,
  output exu_pkg::exu_op_t o_head,
  output logic             o_credit
);

  exu_pkg::exu_op_t mem [exu_pkg::EXU_QDEPTH];
  exu_pkg::qptr_t   wr_ptr_q;
  exu_pkg::qptr_t   rd_ptr_q;
  exu_pkg::qcnt_t   count_q;
  logic             full;
  logic             credit_q;

  function automatic exu_pkg::qptr_t ptr_inc(input exu_pkg::qptr_t ptr);
    return (ptr == exu_pkg::qptr_t'(exu_pkg::EXU_QDEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full         = count_q == exu_pkg::qcnt_t'(exu_pkg::EXU_QDEPTH);
  assign o_head_valid = count_q != '0;
  assign o_head       = mem[rd_ptr_q];
  assign o_credit     = credit_q;

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr_q] <= i_push_op;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // credit goes back one cycle after the pop
      credit_q <= i_pop;
      if (i_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (i_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({i_push, i_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // sender spent a credit it did not hold
  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset) !(i_push && full));
  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_pop && !o_head_valid));

endmodule

//--- hw/exu_alu.sv
// Execute stage ALU

`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::alu_op_e i_op,
  input  exu_pkg::xlen_t   i_src_a,
  input  exu_pkg::xlen_t   i_src_b,
  input  exu_pkg::xlen_t   i_imm,
  input  logic             i_word_cut,
  output exu_pkg::xlen_t   o_result,
  output logic             o_zero,
  output logic             o_less
);

  exu_pkg::xlen_t a;
  exu_pkg::xlen_t b;
  exu_pkg::xlen_t sra_src;
  exu_pkg::xlen_t sum;
  exu_pkg::xlen_t product;
  exu_pkg::xlen_t result;
  exu_pkg::shamt_t shamt;
  logic [64:0]    diff;
  logic           less_s;
  logic           less_u;

  // word ops see zero-extended 32-bit operands
  assign a = i_word_cut ? {32'b0, i_src_a[31:0]} : i_src_a;
  assign b = i_word_cut ? {32'b0, i_src_b[31:0]} : i_src_b;

  // sraw shifts in bit 31 of the word
  assign sra_src = i_word_cut ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign shamt   = i_word_cut ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];

  assign sum     = a + b;
  assign diff    = {1'b0, a} - {1'b0, b};
  assign product = $signed(a) * $signed(b);

  // borrow out gives unsigned less; signs differ means a negative one is smaller
  assign less_u = diff[64];
  assign less_s = (a[63] ^ b[63]) ? a[63] : diff[63];

  assign o_zero = diff[63:0] == '0;
  assign o_less = (i_op == exu_pkg::alu_sltu) ? less_u : less_s;

  always_comb begin
    case (i_op)
      exu_pkg::alu_add:      result = sum;
      exu_pkg::alu_sub:      result = diff[63:0];
      exu_pkg::alu_slt:      result = exu_pkg::xlen_t'(less_s);
      exu_pkg::alu_sltu:     result = exu_pkg::xlen_t'(less_u);
      exu_pkg::alu_xor:      result = a ^ b;
      exu_pkg::alu_or:       result = a | b;
      exu_pkg::alu_and:      result = a & b;
      exu_pkg::alu_sll:      result = a << shamt;
      exu_pkg::alu_srl:      result = a >> shamt;
      exu_pkg::alu_sra:      result = $signed(sra_src) >>> shamt;
      exu_pkg::alu_copy_imm: result = i_imm;
      exu_pkg::alu_mul:      result = product;
      // divide, remainder and system ops are resolved elsewhere
      default:               result = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{result[31]}}, result[31:0]} : result;

endmodule

//--- hw/exu_divider.sv
// Iterative divider

`timescale 1ns/1ps

module exu_divider (
  input  logic             i_clk,
  input  logic             i_reset,
  input  logic             i_start,
  input  exu_pkg::alu_op_e i_op,
  input  logic             i_word_cut,
  input  exu_pkg::xlen_t   i_dividend,
  input  exu_pkg::xlen_t   i_divisor,
  output logic             o_busy,
  output logic             o_done,
  output exu_pkg::xlen_t   o_result
);

  typedef enum logic [1:0] {div_idle, div_calc, div_fix} div_state_e;

  div_state_e        state_q;
  exu_pkg::div_cnt_t cnt_q;
  exu_pkg::xlen_t    quo_q;
  exu_pkg::xlen_t    rem_q;
  exu_pkg::xlen_t    dsor_q;
  exu_pkg::xlen_t    dvnd_q;
  logic              neg_quo_q;
  logic              neg_rem_q;
  logic              is_rem_q;
  logic              cut_q;
  logic              zero_q;

  exu_pkg::xlen_t a_ext;
  exu_pkg::xlen_t b_ext;
  exu_pkg::xlen_t quo_fix;
  exu_pkg::xlen_t rem_fix;
  exu_pkg::xlen_t res;
  logic           is_signed;
  logic           a_neg;
  logic           b_neg;
  logic [64:0]    shifted;
  logic [64:0]    trial;

  assign is_signed = i_op inside {exu_pkg::alu_div, exu_pkg::alu_rem};

  always_comb begin
    a_ext = i_dividend;
    b_ext = i_divisor;
    if (i_word_cut) begin
      a_ext = {{32{is_signed & i_dividend[31]}}, i_dividend[31:0]};
      b_ext = {{32{is_signed & i_divisor[31]}}, i_divisor[31:0]};
    end
  end

  assign a_neg = is_signed & a_ext[63];
  assign b_neg = is_signed & b_ext[63];

  // one restoring step per cycle
  assign shifted = {rem_q, quo_q[63]};
  assign trial   = shifted - {1'b0, dsor_q};

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      quo_q     <= a_neg ? -a_ext : a_ext;
      dsor_q    <= b_neg ? -b_ext : b_ext;
      rem_q     <= '0;
      dvnd_q    <= a_ext;
      neg_quo_q <= a_neg ^ b_neg;
      neg_rem_q <= a_neg;
      is_rem_q  <= i_op inside {exu_pkg::alu_rem, exu_pkg::alu_remu};
      cut_q     <= i_word_cut;
      zero_q    <= b_ext == '0;
    end else if (state_q == div_calc) begin
      quo_q <= {quo_q[62:0], ~trial[64]};
      rem_q <= trial[64] ? shifted[63:0] : trial[63:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state_q <= div_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        div_idle: begin
          if (i_start) begin
            state_q <= div_calc;
            cnt_q   <= '0;
          end
        end
        div_calc: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == exu_pkg::div_cnt_t'(exu_pkg::EXU_DIV_CYCLES - 1)) begin
            state_q <= div_fix;
          end
        end
        default: state_q <= div_idle;
      endcase
    end
  end

  // signs, then the divide-by-zero rule; overflow falls out of the magnitudes
  always_comb begin
    quo_fix = neg_quo_q ? -quo_q : quo_q;
    rem_fix = neg_rem_q ? -rem_q : rem_q;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dvnd_q;
    end
    res = is_rem_q ? rem_fix : quo_fix;
  end

  assign o_result = cut_q ? {{32{res[31]}}, res[31:0]} : res;
  assign o_busy   = state_q != div_idle;
  assign o_done   = state_q == div_fix;

  a_no_start_busy: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_start && o_busy));

endmodule

//--- hw/exu_branch.sv
// Branch resolution and next pc

`timescale 1ns/1ps

module exu_branch (
  input  exu_pkg::branch_e i_branch,
  input  logic             i_zero,
  input  logic             i_less,
  input  exu_pkg::xlen_t   i_pc,
  input  exu_pkg::xlen_t   i_rs1,
  input  exu_pkg::xlen_t   i_imm,
  output exu_pkg::xlen_t   o_next_pc
);

  logic           use_imm;
  exu_pkg::xlen_t base;
  exu_pkg::xlen_t offset;

  always_comb begin
    case (i_branch)
      exu_pkg::br_jal,
      exu_pkg::br_jalr: use_imm = 1'b1;
      exu_pkg::br_beq:  use_imm = i_zero;
      exu_pkg::br_bne:  use_imm = !i_zero;
      exu_pkg::br_blt:  use_imm = i_less;
      exu_pkg::br_bge:  use_imm = !i_less;
      default:          use_imm = 1'b0;
    endcase
  end

  // jalr is the only register-relative target
  assign base      = (i_branch == exu_pkg::br_jalr) ? i_rs1 : i_pc;
  assign offset    = use_imm ? i_imm : exu_pkg::xlen_t'(4);
  assign o_next_pc = base + offset;

endmodule

//--- hw/exu_core.sv
// Execute core

`timescale 1ns/1ps

module exu_core (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_head_valid,
  input  exu_pkg::exu_op_t  i_head,
  input  logic              i_res_credit,
  output logic              o_pop,
  output logic              o_res_valid,
  output exu_pkg::exu_res_t o_res
);

  exu_pkg::exu_op_t  held_q;
  exu_pkg::exu_op_t  cur;
  exu_pkg::wb_cnt_t  credit_q;
  exu_pkg::exu_res_t res_q;
  exu_pkg::exu_res_t res_next;
  logic              res_valid_q;

  exu_pkg::xlen_t    src_a;
  exu_pkg::xlen_t    src_b;
  exu_pkg::xlen_t    alu_out;
  exu_pkg::xlen_t    div_out;
  exu_pkg::xlen_t    alu_result;
  exu_pkg::xlen_t    load_ext;
  exu_pkg::xlen_t    next_pc;
  exu_pkg::alu_op_e  alu_sel;
  exu_pkg::branch_e  br_sel;
  logic              is_div;
  logic              is_sys;
  logic              div_busy;
  logic              div_done;
  logic              zero;
  logic              less;
  logic              res_load;

  // a divide keeps its own copy while the queue head moves on
  assign cur    = div_busy ? held_q : i_head;
  assign is_div = cur.alu_op inside {exu_pkg::alu_div, exu_pkg::alu_divu,
                                     exu_pkg::alu_rem, exu_pkg::alu_remu};
  assign is_sys = cur.alu_op inside {exu_pkg::alu_ebreak, exu_pkg::alu_illegal};
  assign o_pop  = i_head_valid && (credit_q != '0) && !div_busy;

  assign src_a = (cur.asrc == exu_pkg::asrc_pc) ? cur.pc : cur.rs1;

  always_comb begin
    case (cur.bsrc)
      exu_pkg::bsrc_imm:  src_b = cur.imm;
      exu_pkg::bsrc_four: src_b = exu_pkg::xlen_t'(4);
      default:            src_b = cur.rs2;
    endcase
  end

  // conditional branches compare rs1 against rs2
  always_comb begin
    case (cur.branch)
      exu_pkg::br_beq, exu_pkg::br_bne: alu_sel = exu_pkg::alu_sub;
      exu_pkg::br_blt, exu_pkg::br_bge: alu_sel = exu_pkg::alu_slt;
      default:                          alu_sel = cur.alu_op;
    endcase
  end

  assign br_sel = is_sys ? exu_pkg::br_none : cur.branch;

  exu_alu u_alu (
    .i_op       (alu_sel),
    .i_src_a    (src_a),
    .i_src_b    (src_b),
    .i_imm      (cur.imm),
    .i_word_cut (cur.word_cut),
    .o_result   (alu_out),
    .o_zero     (zero),
    .o_less     (less)
  );

  exu_divider u_div (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_start    (o_pop && is_div),
    .i_op       (cur.alu_op),
    .i_word_cut (cur.word_cut),
    .i_dividend (src_a),
    .i_divisor  (src_b),
    .o_busy     (div_busy),
    .o_done     (div_done),
    .o_result   (div_out)
  );

  exu_branch u_branch (
    .i_branch  (br_sel),
    .i_zero    (zero),
    .i_less    (less),
    .i_pc      (cur.pc),
    .i_rs1     (cur.rs1),
    .i_imm     (cur.imm),
    .o_next_pc (next_pc)
  );

  always_comb begin
    case (cur.memop)
      exu_pkg::mem_lb:  load_ext = {{56{cur.rdata[7]}}, cur.rdata[7:0]};
      exu_pkg::mem_lbu: load_ext = {56'b0, cur.rdata[7:0]};
      exu_pkg::mem_lh:  load_ext = {{48{cur.rdata[15]}}, cur.rdata[15:0]};
      exu_pkg::mem_lhu: load_ext = {48'b0, cur.rdata[15:0]};
      exu_pkg::mem_lw:  load_ext = {{32{cur.rdata[31]}}, cur.rdata[31:0]};
      exu_pkg::mem_lwu: load_ext = {32'b0, cur.rdata[31:0]};
      default:          load_ext = cur.rdata;
    endcase
  end

  assign alu_result = div_done ? div_out : alu_out;

  always_comb begin
    res_next.alu_result = alu_result;
    res_next.wb_data    = cur.mem_to_reg ? load_ext : alu_result;
    res_next.next_pc    = next_pc;
    case (cur.alu_op)
      exu_pkg::alu_ebreak:  res_next.status = exu_pkg::st_ebreak;
      exu_pkg::alu_illegal: res_next.status = exu_pkg::st_illegal;
      default:              res_next.status = exu_pkg::st_ok;
    endcase
  end

  assign res_load = (o_pop && !is_div) || div_done;

  always_ff @(posedge i_clk) begin
    if (o_pop && is_div) begin
      held_q <= i_head;
    end
    if (res_load) begin
      res_q <= res_next;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      res_valid_q <= 1'b0;
      credit_q    <= exu_pkg::wb_cnt_t'(exu_pkg::EXU_WB_CREDITS);
    end else begin
      res_valid_q <= res_load;
      // a credit is spent at issue, so a divide holds its slot
      case ({o_pop, i_res_credit})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign o_res_valid = res_valid_q;
  assign o_res       = res_q;

  // write-back returned more slots than it has
  a_credit_max: assert property (@(posedge i_clk) disable iff (i_reset)
    credit_q <= exu_pkg::wb_cnt_t'(exu_pkg::EXU_WB_CREDITS));

endmodule

//--- hw/exu_top.sv
// Execute stage top level

`timescale 1ns/1ps

module exu_top (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_op_valid,
  input  exu_pkg::exu_op_t  i_op,
  input  logic              i_res_credit,
  output logic              o_op_credit,
  output logic              o_res_valid,
  output exu_pkg::exu_res_t o_res
);

  logic             head_valid;
  exu_pkg::exu_op_t head;
  logic             pop;

  exu_issue_fifo u_fifo (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_push       (i_op_valid),
    .i_push_op    (i_op),
    .i_pop        (pop),
    .o_head_valid (head_valid),
    .o_head       (head),
    .o_credit     (o_op_credit)
  );

  exu_core u_core (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_head_valid (head_valid),
    .i_head       (head),
    .i_res_credit (i_res_credit),
    .o_pop        (pop),
    .o_res_valid  (o_res_valid),
    .o_res        (o_res)
  );

endmodule

//--- tb/tb_clkgen.sv
// Testbench clock source

`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // 8 ns period
  always begin
    #4 o_clk = ~o_clk;
  end

endmodule

//--- tb/tb_exu.sv
// Execute stage testbench

`timescale 1ns/1ps

module tb_exu;

  logic              clk;
  logic              reset;
  logic              op_valid;
  exu_pkg::exu_op_t  op_data;
  logic              res_credit;
  logic              op_credit;
  logic              res_valid;
  exu_pkg::exu_res_t res_data;

  exu_pkg::exu_op_t  send_q [$];
  exu_pkg::exu_res_t exp_q [$];
  exu_pkg::exu_res_t exp_res;
  integer            seed = 32'h5455;
  int                errors = 0;
  int                op_sent = 0;
  int                op_returned = 0;
  int                res_rcvd = 0;
  int                res_freed = 0;
  int                delay_cnt = 0;
  logic              hold_credits = 1'b0;
  logic              aborted = 1'b0;
  string             test_name = "reset";

  tb_clkgen u_clk (.o_clk(clk));

  exu_top dut (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_op_valid   (op_valid),
    .i_op         (op_data),
    .i_res_credit (res_credit),
    .o_op_credit  (op_credit),
    .o_res_valid  (res_valid),
    .o_res        (res_data)
  );

  function automatic exu_pkg::xlen_t sext32(input exu_pkg::xlen_t v);
    return {{32{v[31]}}, v[31:0]};
  endfunction

  function automatic exu_pkg::xlen_t ref_div(input exu_pkg::alu_op_e op, input exu_pkg::xlen_t x,
                                             input exu_pkg::xlen_t y, input logic wc);
    logic           sgn;
    exu_pkg::xlen_t q;
    exu_pkg::xlen_t r;
    sgn = op inside {exu_pkg::alu_div, exu_pkg::alu_rem};
    // unsigned word operands are already zero-extended
    if (wc && sgn) begin
      x = sext32(x);
      y = sext32(y);
    end
    if (y == '0) begin
      q = '1;
      r = x;
    end else if (sgn && x == {1'b1, 63'b0} && y == '1) begin
      q = x;
      r = '0;
    end else if (sgn) begin
      q = $signed(x) / $signed(y);
      r = $signed(x) % $signed(y);
    end else begin
      q = x / y;
      r = x % y;
    end
    return (op inside {exu_pkg::alu_rem, exu_pkg::alu_remu}) ? r : q;
  endfunction

  function automatic exu_pkg::xlen_t ref_alu(input exu_pkg::alu_op_e op, input exu_pkg::xlen_t a,
                                             input exu_pkg::xlen_t b, input exu_pkg::xlen_t imm,
                                             input logic wc);
    exu_pkg::xlen_t r;
    logic [5:0]     sh;
    if (wc) begin
      a = {32'b0, a[31:0]};
      b = {32'b0, b[31:0]};
    end
    sh = wc ? {1'b0, b[4:0]} : b[5:0];
    case (op)
      exu_pkg::alu_add:      r = a + b;
      exu_pkg::alu_sub:      r = a - b;
      exu_pkg::alu_slt:      r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      exu_pkg::alu_sltu:     r = (a < b) ? 64'd1 : 64'd0;
      exu_pkg::alu_xor:      r = a ^ b;
      exu_pkg::alu_or:       r = a | b;
      exu_pkg::alu_and:      r = a & b;
      exu_pkg::alu_sll:      r = a << sh;
      exu_pkg::alu_srl:      r = a >> sh;
      // sraw shifts in bit 31 of the word
      exu_pkg::alu_sra:      r = $signed(wc ? sext32(a) : a) >>> sh;
      exu_pkg::alu_copy_imm: r = imm;
      exu_pkg::alu_mul:      r = a * b;
      exu_pkg::alu_div, exu_pkg::alu_divu,
      exu_pkg::alu_rem, exu_pkg::alu_remu: r = ref_div(op, a, b, wc);
      default:               r = '0;
    endcase
    return wc ? sext32(r) : r;
  endfunction

  function automatic exu_pkg::exu_res_t ref_result(input exu_pkg::exu_op_t op);
    exu_pkg::exu_res_t r;
    exu_pkg::xlen_t    a;
    exu_pkg::xlen_t    b;
    exu_pkg::xlen_t    ld;
    exu_pkg::alu_op_e  aop;
    logic              taken;
    a = (op.asrc == exu_pkg::asrc_pc) ? op.pc : op.rs1;
    case (op.bsrc)
      exu_pkg::bsrc_imm:  b = op.imm;
      exu_pkg::bsrc_four: b = 64'd4;
      default:            b = op.rs2;
    endcase
    aop = op.alu_op;
    if (op.branch inside {exu_pkg::br_beq, exu_pkg::br_bne}) aop = exu_pkg::alu_sub;
    if (op.branch inside {exu_pkg::br_blt, exu_pkg::br_bge}) aop = exu_pkg::alu_slt;
    case (op.branch)
      exu_pkg::br_beq: taken = a == b;
      exu_pkg::br_bne: taken = a != b;
      exu_pkg::br_blt: taken = $signed(a) < $signed(b);
      exu_pkg::br_bge: taken = $signed(a) >= $signed(b);
      default:         taken = op.branch inside {exu_pkg::br_jal, exu_pkg::br_jalr};
    endcase
    case (op.memop)
      exu_pkg::mem_lb:  ld = {{56{op.rdata[7]}}, op.rdata[7:0]};
      exu_pkg::mem_lbu: ld = {56'b0, op.rdata[7:0]};
      exu_pkg::mem_lh:  ld = {{48{op.rdata[15]}}, op.rdata[15:0]};
      exu_pkg::mem_lhu: ld = {48'b0, op.rdata[15:0]};
      exu_pkg::mem_lw:  ld = {{32{op.rdata[31]}}, op.rdata[31:0]};
      exu_pkg::mem_lwu: ld = {32'b0, op.rdata[31:0]};
      default:          ld = op.rdata;
    endcase
    r.alu_result = ref_alu(aop, a, b, op.imm, op.word_cut);
    r.wb_data    = op.mem_to_reg ? ld : r.alu_result;
    r.next_pc    = ((op.branch == exu_pkg::br_jalr) ? op.rs1 : op.pc) + (taken ? op.imm : 64'd4);
    r.status     = exu_pkg::st_ok;
    if (op.alu_op == exu_pkg::alu_ebreak) r.status = exu_pkg::st_ebreak;
    if (op.alu_op == exu_pkg::alu_illegal) r.status = exu_pkg::st_illegal;
    if (r.status != exu_pkg::st_ok) r.next_pc = op.pc + 64'd4;
    return r;
  endfunction

  function automatic exu_pkg::exu_op_t make_op(input exu_pkg::alu_op_e alu_op,
                                               input exu_pkg::xlen_t rs1, input exu_pkg::xlen_t rs2,
                                               input exu_pkg::xlen_t imm);
    exu_pkg::exu_op_t op;
    op        = '0;
    op.alu_op = alu_op;
    op.rs1    = rs1;
    op.rs2    = rs2;
    op.imm    = imm;
    op.pc     = 64'h8000_1000;
    return op;
  endfunction

  task automatic queue_op(input exu_pkg::exu_op_t op);
    send_q.push_back(op);
    exp_q.push_back(ref_result(op));
  endtask

  task automatic wait_drain();
    int cycles = 0;
    while ((send_q.size() > 0 || exp_q.size() > 0) && cycles < 10000) begin
      @(posedge clk);
      cycles++;
    end
    // let the monitor counters settle
    @(posedge clk);
    assert (send_q.size() == 0 && exp_q.size() == 0) else begin
      errors++;
      aborted = 1'b1;
      $display("timeout in %s with %0d results still missing", test_name, exp_q.size());
    end
  endtask

  // upstream sender spends one credit per operation
  always @(posedge clk) begin
    op_valid <= 1'b0;
    if (!reset && send_q.size() > 0 && op_sent - op_returned < exu_pkg::EXU_QDEPTH) begin
      op_valid <= 1'b1;
      op_data  <= send_q.pop_front();
      op_sent  <= op_sent + 1;
    end
  end

  always @(posedge clk) begin
    if (!reset && op_credit) begin
      op_returned <= op_returned + 1;
      assert (op_returned < op_sent) else begin
        errors++;
        $display("upstream got a credit back with no operation outstanding in %s", test_name);
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && res_valid) begin
      res_rcvd <= res_rcvd + 1;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("a result came out with no operation outstanding in %s", test_name);
      end
      if (exp_q.size() > 0) begin
        exp_res = exp_q.pop_front();
        assert (res_data == exp_res) else begin
          errors++;
          $display("ERROR %s expected %h actual %h", test_name, exp_res, res_data);
        end
      end
    end
  end

  // write-back frees slots after a random delay
  always @(posedge clk) begin
    res_credit <= 1'b0;
    if (!reset && !hold_credits && res_rcvd > res_freed) begin
      if (delay_cnt == 0) begin
        res_credit <= 1'b1;
        res_freed  <= res_freed + 1;
        delay_cnt  <= $random(seed) & 3;
      end else begin
        delay_cnt <= delay_cnt - 1;
      end
    end
  end

  task automatic test_alu();
    exu_pkg::alu_op_e ops [12] = '{exu_pkg::alu_add, exu_pkg::alu_sub, exu_pkg::alu_slt,
                                   exu_pkg::alu_sltu, exu_pkg::alu_xor, exu_pkg::alu_or,
                                   exu_pkg::alu_and, exu_pkg::alu_sll, exu_pkg::alu_srl,
                                   exu_pkg::alu_sra, exu_pkg::alu_copy_imm, exu_pkg::alu_mul};
    exu_pkg::xlen_t   a;
    exu_pkg::xlen_t   b;
    exu_pkg::exu_op_t op;
    if (aborted) return;
    test_name = "alu";
    for (int k = 0; k < 4; k++) begin
      a = (k == 0) ? 64'hFFFF_FFFF_8765_4321 : {$random(seed), $random(seed)};
      b = (k == 0) ? 64'h25 : {$random(seed), $random(seed)};
      for (int i = 0; i < 12; i++) begin
        op = make_op(ops[i], a, b, 64'hFFFF_FFFF_FFFF_F9A0);
        queue_op(op);
        op.word_cut = 1'b1;
        queue_op(op);
      end
    end
    // pc plus immediate as in auipc
    op      = make_op(exu_pkg::alu_add, a, b, 64'h1234_5000);
    op.asrc = exu_pkg::asrc_pc;
    op.bsrc = exu_pkg::bsrc_imm;
    queue_op(op);
    wait_drain();
  endtask

  task automatic test_branch();
    exu_pkg::branch_e brs [4] = '{exu_pkg::br_beq, exu_pkg::br_bne, exu_pkg::br_blt,
                                  exu_pkg::br_bge};
    exu_pkg::xlen_t   lhs [3] = '{64'd7, -64'd5, 64'd3};
    exu_pkg::xlen_t   rhs [3] = '{64'd7, 64'd3, -64'd5};
    exu_pkg::exu_op_t op;
    if (aborted) return;
    test_name = "branch";
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 3; k++) begin
        op        = make_op(exu_pkg::alu_add, lhs[k], rhs[k], 64'h40);
        op.imm    = (k == 1) ? 64'hFFFF_FFFF_FFFF_FFF0 : 64'h40;
        op.branch = brs[i];
        op.pc     = 64'h8000_2000 + 16 * k;
        queue_op(op);
      end
    end
    op        = make_op(exu_pkg::alu_add, '0, '0, 64'h100);
    op.asrc   = exu_pkg::asrc_pc;
    op.bsrc   = exu_pkg::bsrc_four;
    op.branch = exu_pkg::br_jal;
    queue_op(op);
    op.rs1    = 64'h8000_3000;
    op.imm    = 64'h24;
    op.branch = exu_pkg::br_jalr;
    queue_op(op);
    wait_drain();
  endtask

  task automatic test_load();
    exu_pkg::xlen_t   pats [2] = '{64'h8123_4567_89AB_CDEF, 64'h7F6E_5D4C_3B2A_1908};
    exu_pkg::exu_op_t op;
    if (aborted) return;
    test_name = "load";
    for (int p = 0; p < 2; p++) begin
      for (int m = 0; m < 7; m++) begin
        op            = make_op(exu_pkg::alu_add, 64'h1000, '0, 64'h18);
        op.bsrc       = exu_pkg::bsrc_imm;
        op.memop      = exu_pkg::memop_e'(m);
        op.mem_to_reg = 1'b1;
        op.rdata      = pats[p];
        queue_op(op);
      end
    end
    wait_drain();
  endtask

  task automatic test_divide();
    exu_pkg::alu_op_e ops [4] = '{exu_pkg::alu_div, exu_pkg::alu_divu, exu_pkg::alu_rem,
                                  exu_pkg::alu_remu};
    // last two pairs hit the 64-bit and 32-bit overflow cases
    exu_pkg::xlen_t   lhs [5] = '{-64'd20, 64'd20, 64'd77, 64'h8000_0000_0000_0000,
                                  64'hFFFF_FFFF_8000_0000};
    exu_pkg::xlen_t   rhs [5] = '{64'd6, -64'd6, 64'd0, '1, '1};
    exu_pkg::exu_op_t op;
    if (aborted) return;
    test_name = "divide";
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 5; k++) begin
        op = make_op(ops[i], lhs[k], rhs[k], '0);
        queue_op(op);
        op.word_cut = 1'b1;
        queue_op(op);
      end
    end
    queue_op(make_op(exu_pkg::alu_add, 64'd1, 64'd2, '0));
    wait_drain();
  endtask

  task automatic test_backpressure();
    int n_ops = exu_pkg::EXU_QDEPTH + exu_pkg::EXU_WB_CREDITS + 1;
    int rcvd_start;
    int ret_mark;
    int cycles = 0;
    if (aborted) return;
    test_name = "backpressure";
    while (res_freed != res_rcvd && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    assert (res_freed == res_rcvd) else begin
      errors++;
      $display("write-back slots were never freed before the stall");
    end
    @(posedge clk);
    hold_credits <= 1'b1;
    rcvd_start = res_rcvd;
    for (int k = 0; k < n_ops; k++) begin
      queue_op(make_op(exu_pkg::alu_add, 64'h100 * k, 64'd7, '0));
    end
    for (int c = 0; c < 40; c++) begin
      @(posedge clk);
      if (c == 20) ret_mark = op_returned;
    end
    assert (res_rcvd - rcvd_start <= exu_pkg::EXU_WB_CREDITS) else begin
      errors++;
      $display("more results than write-back slots came out while slots were held");
    end
    assert (op_returned == ret_mark) else begin
      errors++;
      $display("upstream credits kept coming back with the queue full");
    end
    assert (op_sent - op_returned == exu_pkg::EXU_QDEPTH) else begin
      errors++;
      $display("queue did not fill while write-back was stalled");
    end
    hold_credits <= 1'b0;
    wait_drain();
    assert (res_rcvd - rcvd_start == n_ops) else begin
      errors++;
      $display("%0d results arrived for %0d operations", res_rcvd - rcvd_start, n_ops);
    end
  endtask

  task automatic test_system();
    exu_pkg::exu_op_t op;
    if (aborted) return;
    test_name = "system";
    // jump fields on a system op leave the pc at pc+4
    op        = make_op(exu_pkg::alu_ebreak, 64'd1, 64'd2, 64'h80);
    op.pc     = 64'h8000_4000;
    op.branch = exu_pkg::br_jal;
    queue_op(op);
    op        = make_op(exu_pkg::alu_illegal, 64'd3, 64'd4, 64'h80);
    op.pc     = 64'h8000_4008;
    op.branch = exu_pkg::br_jalr;
    queue_op(op);
    wait_drain();
  endtask

  initial begin
    reset      = 1'b1;
    op_valid   = 1'b0;
    op_data    = '0;
    res_credit = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_alu();
    test_branch();
    test_load();
    test_divide();
    test_backpressure();
    test_system();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- src.f
hw/exu_pkg.sv
hw/exu_issue_fifo.sv
hw/exu_alu.sv
hw/exu_divider.sv
hw/exu_branch.sv
hw/exu_core.sv
hw/exu_top.sv
tb/tb_clkgen.sv
tb/tb_exu.sv

//--- Bender.yml
package:
  name: rv64_exu

sources:
  - files:
      - hw/exu_pkg.sv
      - hw/exu_issue_fifo.sv
      - hw/exu_alu.sv
      - hw/exu_divider.sv
      - hw/exu_branch.sv
      - hw/exu_core.sv
      - hw/exu_top.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/tb_exu.sv
